// ==== dv/front_end_asserts.sv ====
`timescale 1ns/1ps

module front_end_asserts import fe_types_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     jmp,
    input logic     req_valid,
    input mem_req_t req,
    input logic     req_accept,
    input logic     iq_valid
);

    // Failures seen so far, read by the testbench at the end.
    int fail_cnt = 0;

    // Requests always name a whole line.
    req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (req.addr[$clog2(LINE_BYTES)-1:0] == '0))
    else begin
        fail_cnt++;
        $error("request address %h is not line aligned", req.addr);
    end

    // A pending request keeps its address until memory takes it.
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_accept && !jmp |=> req_valid && $stable(req.addr))
    else begin
        fail_cnt++;
        $error("request dropped or changed before it was accepted");
    end

    // Queue starts out empty.
    iq_empty_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !iq_valid)
    else begin
        fail_cnt++;
        $error("queue shows an entry right after reset");
    end

    // Jump flushes the queue.
    iq_empty_after_jmp: assert property (@(posedge clk) disable iff (!rst_n)
        jmp |=> !iq_valid)
    else begin
        fail_cnt++;
        $error("queue shows an entry right after a jump");
    end

endmodule

bind front_end front_end_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .jmp(jmp), .req_valid(req_valid),
    .req(req), .req_accept(req_accept), .iq_valid(iq_valid)
);

// ==== dv/front_end_tb.sv ====
`timescale 1ns/1ps

module front_end_tb import fe_types_pkg::*; ();

    localparam int IDB_LEN         = 64;
    localparam int IQ_LEN          = 8;
    localparam int MAX_OUTSTANDING = 4;
    localparam int unsigned SEED   = 32'hcd8b_caf3;

    // Test lengths in popped entries.
    localparam int STRAIGHT_POPS = 300;
    localparam int N_JUMPS       = 20;
    localparam int JUMP_POPS     = 10;
    localparam int N_STALLS      = 3;
    localparam int STALL_POPS    = 40;
    localparam int STALL_CYCLES  = 150;
    localparam int TOTAL_INSTR   = STRAIGHT_POPS + N_JUMPS * JUMP_POPS + N_STALLS * STALL_POPS;
    localparam int CYCLE_LIMIT   = 40 * TOTAL_INSTR;

    logic      clk;
    logic      rst_n;
    addr_t     pc;
    logic      jmp;
    iq_entry_t iq_entry;
    logic      iq_valid;
    logic      iq_pop;
    logic      req_valid;
    mem_req_t  req;
    logic      req_accept;
    logic      rsp_valid;
    mem_rsp_t  rsp;

    // Model and memory state.
    addr_t       exp_addr;
    addr_t       target_addr;
    addr_t       rsp_addr_q[$];
    int          rsp_due_q[$];
    int          acc_wait;
    int          wait_draw;
    int          last_due;
    int          due;
    int          pops;
    int          errors;
    int          unknown_seen;
    int          cycles;
    logic        pop_en;
    string       test_name;

    front_end #(
        .IDB_LEN(IDB_LEN), .IQ_LEN(IQ_LEN), .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) DUT (
        .clk(clk), .rst_n(rst_n), .pc(pc), .jmp(jmp), .iq_entry(iq_entry),
        .iq_valid(iq_valid), .iq_pop(iq_pop), .req_valid(req_valid), .req(req),
        .req_accept(req_accept), .rsp_valid(rsp_valid), .rsp(rsp)
    );

    always #2 clk = ~clk;

    // Memory content is a hash over every address bit.
    function automatic byte_t mem_byte(input addr_t a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic mem_rsp_t reply_for(input addr_t a);
        mem_rsp_t r;
        r.addr = a;
        for (int j = 0; j < LINE_BYTES; j++) begin
            r.data[8*j +: 8] = mem_byte(a + addr_t'(j));
        end
        return r;
    endfunction

    // Length from the unit code and format bits of byte 0.
    function automatic int ref_len(input byte_t b);
        case (b[2:0])
            3'd4: return b[3] ? 6 : 2;
            3'd2: return b[3] ? 2 : (b[4] ? 3 : 6);
            3'd6: return b[3] ? 5 : 1;
            default: return 1;
        endcase
    endfunction

    task automatic check_value(input string field, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (act_v !== exp_v) begin
            errors++;
            $display("ERROR %s %s: expected %0h, actual %0h", test_name, field, exp_v, act_v);
        end
    endtask

    // Compare a popped entry with the walk over the memory image.
    task automatic compare_entry();
        ibits_t bits;
        byte_t  b0;
        int     len;
        b0 = mem_byte(exp_addr);
        len = ref_len(b0);
        bits = '0;
        for (int i = 0; i < len; i++) begin
            bits[8*i +: 8] = mem_byte(exp_addr + addr_t'(i));
        end
        check_value("addr", 64'(exp_addr), 64'(iq_entry.addr));
        check_value("len", 64'(len), 64'(iq_entry.len));
        check_value("bits", 64'(bits), 64'(iq_entry.bits));
        // Unknown unit code takes a single byte.
        if (!(b0[2:0] inside {3'd2, 3'd4, 3'd6})) begin
            unknown_seen++;
            check_value("unknown len", 64'd1, 64'(iq_entry.len));
        end
        exp_addr = exp_addr + addr_t'(len);
    endtask

    task automatic wait_pops(input int n);
        int target;
        target = pops + n;
        while (pops < target) begin
            @(posedge clk);
        end
    endtask

    // Accept after 0 to 3 cycles and answer in order 1 to 5 cycles later.
    always @(posedge clk) begin
        if (!rst_n) begin
            rsp_addr_q.delete();
            rsp_due_q.delete();
            req_accept <= 1'b0;
            rsp_valid  <= 1'b0;
            iq_pop     <= 1'b0;
        end else begin
            if (req_valid && req_accept) begin
                due = cycles + int'($urandom % 5);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rsp_addr_q.push_back(req.addr);
                rsp_due_q.push_back(due);
                // A zero wait keeps accept up for the next request.
                wait_draw = int'($urandom % 4);
                req_accept <= (wait_draw == 0);
                acc_wait   <= wait_draw;
            end else if (req_valid && !req_accept) begin
                if (acc_wait <= 1) begin
                    req_accept <= 1'b1;
                end else begin
                    acc_wait <= acc_wait - 1;
                end
            end
            rsp_valid <= 1'b0;
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycles) begin
                rsp_valid <= 1'b1;
                rsp       <= reply_for(rsp_addr_q.pop_front());
                void'(rsp_due_q.pop_front());
            end
            iq_pop <= pop_en && ($urandom % 4 != 0);
        end
    end

    // Pops are checked before a jump in the same cycle retargets the model.
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_addr = '0;
        end else begin
            if (iq_valid && iq_pop) begin
                compare_entry();
                pops <= pops + 1;
            end
            if (jmp) begin
                exp_addr = pc;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        rst_n = 1'b0;
        jmp = 1'b0;
        pc = '0;
        iq_pop = 1'b0;
        req_accept = 1'b0;
        rsp_valid = 1'b0;
        rsp = '0;
        pop_en = 1'b0;
        exp_addr = '0;
        acc_wait = 0;
        wait_draw = 0;
        last_due = 0;
        pops = 0;
        errors = 0;
        unknown_seen = 0;
        cycles = 0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Straight-line decode from address 0.
        test_name <= "straight";
        pop_en    <= 1'b1;
        wait_pops(STRAIGHT_POPS);
        if (unknown_seen == 0) begin
            errors++;
            $display("No entry with an unknown unit code was popped in the straight test");
        end

        // Jumps with requests and replies in flight.
        // Every fourth target is line aligned.
        test_name <= "jump";
        for (int j = 0; j < N_JUMPS; j++) begin
            repeat (int'($urandom % 6)) @(posedge clk);
            target_addr = $urandom & 32'h000f_ffff;
            if (j % 4 == 0) begin
                target_addr[3:0] = 4'h0;
            end
            pc  <= target_addr;
            jmp <= 1'b1;
            @(posedge clk);
            jmp <= 1'b0;
            wait_pops(JUMP_POPS);
        end

        // Long stalls fill the queue and the buffer, so fetching stops.
        test_name <= "backpressure";
        for (int s = 0; s < N_STALLS; s++) begin
            pop_en <= 1'b0;
            repeat (STALL_CYCLES) @(posedge clk);
            check_value("fetch stopped", 64'd0, 64'(req_valid));
            pop_en <= 1'b1;
            wait_pops(STALL_POPS);
        end

        pop_en <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        errors = errors + DUT.u_asserts.fail_cnt;
        $display("Entries checked: %0d, errors: %0d", pops, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/fe_types_pkg.sv
logic/isa_pkg.sv
logic/pc_tracker.sv
logic/fetch_unit.sv
logic/byte_buffer.sv
logic/length_decoder.sv
logic/instr_queue.sv
logic/front_end.sv
dv/front_end_asserts.sv
dv/front_end_tb.sv

// ==== logic/byte_buffer.sv ====
`timescale 1ns/1ps

module byte_buffer import fe_types_pkg::*; #(
    parameter int IDB_LEN = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  line_t                       push_bytes,
    input  logic [LINE_BYTES-1:0]       push_mask,
    input  logic [$clog2(LINE_BYTES):0] push_count,
    input  ilen_t                       pop_len,
    output byte_t [MAX_INST_BYTES-1:0]  head_bytes,
    output logic [$clog2(IDB_LEN):0]    fill_count,
    output logic [$clog2(IDB_LEN):0]    free_count
);

    localparam int FC_W = $clog2(IDB_LEN) + 1;

    byte_t [IDB_LEN-1:0]    bytes_q;
    byte_t [IDB_LEN-1:0]    bytes_n;
    byte_t [LINE_BYTES-1:0] push_packed;
    logic [FC_W-1:0]        base;

    // Fill level once the head bytes are gone, where new bytes land.
    assign base = fill_count - FC_W'(pop_len);

    // Gather the masked bytes to the bottom, in their original order.
    always_comb begin
        int k;
        k = 0;
        push_packed = '0;
        for (int j = 0; j < LINE_BYTES; j++) begin
            if (push_mask[j]) begin
                push_packed[k] = push_bytes[8*j +: 8];
                k = k + 1;
            end
        end
    end

    // Shift out the popped bytes and append the new ones right behind the rest.
    always_comb begin
        for (int i = 0; i < IDB_LEN; i++) begin
            if (i >= int'(base) && i < int'(base) + int'(push_count)) begin
                bytes_n[i] = push_packed[i - int'(base)];
            end else if (i + int'(pop_len) < IDB_LEN) begin
                bytes_n[i] = bytes_q[i + int'(pop_len)];
            end else begin
                bytes_n[i] = '0;
            end
        end
    end

    // Byte storage, only the fill count says what is valid.
    always_ff @(posedge clk) begin
        bytes_q <= bytes_n;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            fill_count <= '0;
        end else begin
            fill_count <= base + FC_W'(push_count);
        end
    end

    assign head_bytes = bytes_q[MAX_INST_BYTES-1:0];
    assign free_count = FC_W'(IDB_LEN) - fill_count;

endmodule

// ==== logic/fe_types_pkg.sv ====
package fe_types_pkg;

    // One memory line, in bytes.
    localparam int LINE_BYTES = 16;

    // Longest instruction the decoder can see at the buffer head.
    localparam int MAX_INST_BYTES = 6;

    // Byte address in the code space.
    typedef logic [31:0] addr_t;

    typedef logic [7:0] byte_t;

    // Whole memory line, byte 0 in the low bits.
    typedef logic [8*LINE_BYTES-1:0] line_t;

    // Instruction length in bytes, 1 to 6.
    typedef logic [2:0] ilen_t;

    // Raw instruction bytes, byte 0 lowest.
    typedef logic [8*MAX_INST_BYTES-1:0] ibits_t;

    // Line read request, the address is always line aligned.
    typedef struct packed {
        addr_t addr;
    } mem_req_t;

    // Line read reply.
    typedef struct packed {
        addr_t addr;
        line_t data;
    } mem_rsp_t;

    // One decoded instruction as the back end sees it.
    typedef struct packed {
        ibits_t bits;
        addr_t  addr;
        ilen_t  len;
    } iq_entry_t;

endpackage

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import fe_types_pkg::*; #(
    parameter int IDB_LEN         = 64,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        jmp,
    input  addr_t                       fetch_addr,
    input  logic [$clog2(IDB_LEN):0]    free_count,
    output logic                        req_valid,
    output mem_req_t                    req,
    input  logic                        req_accept,
    output logic                        req_taken,
    input  logic                        rsp_valid,
    input  mem_rsp_t                    rsp,
    output line_t                       push_bytes,
    output logic [LINE_BYTES-1:0]       push_mask,
    output logic [$clog2(LINE_BYTES):0] push_count
);

    localparam int OFS_W = $clog2(LINE_BYTES);
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    logic [CNT_W-1:0] live_cnt;
    logic [CNT_W-1:0] stale_cnt;
    logic [CNT_W-1:0] live_cnt_n;
    logic [CNT_W-1:0] stale_cnt_n;
    logic [OFS_W-1:0] first_ofs;
    logic             live_rsp;
    logic             drop_rsp;
    int               room;

    // Buffer space not yet promised to lines in flight or to the pending push.
    assign room = int'(free_count) - LINE_BYTES * int'(live_cnt) - int'(push_count);

    // Stale requests still count against the limit, they hold a slot in memory.
    assign req_valid = (room >= LINE_BYTES) &&
                       (int'(live_cnt) + int'(stale_cnt) < MAX_OUTSTANDING);
    assign req.addr  = {fetch_addr[$bits(addr_t)-1:OFS_W], {OFS_W{1'b0}}};
    assign req_taken = req_valid && req_accept;

    // Replies come back in issue order, so stale ones arrive first.
    assign drop_rsp = rsp_valid && (stale_cnt != '0);
    assign live_rsp = rsp_valid && (stale_cnt == '0);

    assign live_cnt_n  = live_cnt + CNT_W'(req_taken) - CNT_W'(live_rsp);
    assign stale_cnt_n = stale_cnt - CNT_W'(drop_rsp);

    // A jump turns everything in flight stale, a request taken in the same cycle included.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            live_cnt  <= '0;
            stale_cnt <= '0;
        end else if (jmp) begin
            live_cnt  <= '0;
            stale_cnt <= stale_cnt_n + live_cnt_n;
        end else begin
            live_cnt  <= live_cnt_n;
            stale_cnt <= stale_cnt_n;
        end
    end

    // Only the first line after an unaligned jump starts inside the line.
    // No live reply can arrive before that request is taken.
    always_ff @(posedge clk) begin
        if (!rst_n || jmp) begin
            first_ofs <= '0;
        end else if (req_taken && (fetch_addr[OFS_W-1:0] != '0)) begin
            first_ofs <= fetch_addr[OFS_W-1:0];
        end else if (live_rsp) begin
            first_ofs <= '0;
        end
    end

    // One live reply becomes one push at the next edge.
    always_ff @(posedge clk) begin
        if (!rst_n || jmp) begin
            push_mask  <= '0;
            push_count <= '0;
        end else if (live_rsp) begin
            push_mask  <= {LINE_BYTES{1'b1}} << first_ofs;
            push_count <= (OFS_W+1)'(LINE_BYTES - int'(first_ofs));
        end else begin
            push_mask  <= '0;
            push_count <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (live_rsp) begin
            push_bytes <= rsp.data;
        end
    end

endmodule

// ==== logic/front_end.sv ====
`timescale 1ns/1ps

module front_end import fe_types_pkg::*; #(
    parameter int IDB_LEN         = 64,
    parameter int IQ_LEN          = 8,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  addr_t     pc,
    input  logic      jmp,
    output iq_entry_t iq_entry,
    output logic      iq_valid,
    input  logic      iq_pop,
    output logic      req_valid,
    output mem_req_t  req,
    input  logic      req_accept,
    input  logic      rsp_valid,
    input  mem_rsp_t  rsp
);

    addr_t                       decode_addr;
    addr_t                       fetch_addr;
    ilen_t                       pop_len;
    logic                        req_taken;
    line_t                       push_bytes;
    logic [LINE_BYTES-1:0]       push_mask;
    logic [$clog2(LINE_BYTES):0] push_count;
    logic [$clog2(IDB_LEN):0]    free_count;
    logic [$clog2(IDB_LEN):0]    fill_count;
    byte_t [MAX_INST_BYTES-1:0]  head_bytes;
    iq_entry_t                   entry;
    logic                        push;
    logic                        full;

    // Both addresses, reloaded on a jump.
    pc_tracker u_pc_tracker (
        .clk(clk), .rst_n(rst_n), .jmp(jmp), .pc(pc), .pop_len(pop_len),
        .req_taken(req_taken), .decode_addr(decode_addr), .fetch_addr(fetch_addr)
    );

    fetch_unit #(.IDB_LEN(IDB_LEN), .MAX_OUTSTANDING(MAX_OUTSTANDING)) u_fetch_unit (
        .clk(clk), .rst_n(rst_n), .jmp(jmp), .fetch_addr(fetch_addr),
        .free_count(free_count), .req_valid(req_valid), .req(req),
        .req_accept(req_accept), .req_taken(req_taken), .rsp_valid(rsp_valid),
        .rsp(rsp), .push_bytes(push_bytes), .push_mask(push_mask), .push_count(push_count)
    );

    // The jump flushes the byte buffer and the queue.
    byte_buffer #(.IDB_LEN(IDB_LEN)) u_byte_buffer (
        .clk(clk), .rst_n(rst_n), .flush(jmp), .push_bytes(push_bytes),
        .push_mask(push_mask), .push_count(push_count), .pop_len(pop_len),
        .head_bytes(head_bytes), .fill_count(fill_count), .free_count(free_count)
    );

    length_decoder #(.IDB_LEN(IDB_LEN)) u_length_decoder (
        .head_bytes(head_bytes), .fill_count(fill_count), .decode_addr(decode_addr),
        .full(full), .entry(entry), .push(push), .pop_len(pop_len)
    );

    instr_queue #(.IQ_LEN(IQ_LEN)) u_instr_queue (
        .clk(clk), .rst_n(rst_n), .flush(jmp), .push(push), .entry(entry),
        .pop(iq_pop), .head(iq_entry), .valid(iq_valid), .full(full)
    );

endmodule

// ==== logic/instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue import fe_types_pkg::*; #(
    parameter int IQ_LEN = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      push,
    input  iq_entry_t entry,
    input  logic      pop,
    output iq_entry_t head,
    output logic      valid,
    output logic      full
);

    localparam int PTR_W = (IQ_LEN > 1) ? $clog2(IQ_LEN) : 1;
    localparam int CNT_W = $clog2(IQ_LEN + 1);

    iq_entry_t        slots [IQ_LEN];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer step with wrap, depth need not be a power of two.
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(IQ_LEN - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= entry;
        end
    end

    // Flush drops every entry at once.
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    assign head  = slots[rd_ptr];
    assign valid = (count != '0);
    assign full  = (count == CNT_W'(IQ_LEN));

endmodule

// ==== logic/isa_pkg.sv ====
package isa_pkg;

    // Unit code in bits 2:0 of the first instruction byte.
    typedef enum logic [2:0] {
        UNIT_MEM  = 3'b010,
        UNIT_ALU  = 3'b100,
        UNIT_FLOW = 3'b110
    } unit_e;

    // Format bits of the first byte.
    localparam int IMM_BIT = 3;
    localparam int GIO_BIT = 4;

    // ALU forms.
    localparam logic [2:0] ALU_IMM_LEN = 3'd6;
    localparam logic [2:0] ALU_REG_LEN = 3'd2;

    // Memory and IO forms.
    localparam logic [2:0] MEM_LDST_LEN = 3'd6;
    localparam logic [2:0] MEM_GIO_LEN  = 3'd3;
    localparam logic [2:0] MEM_REG_LEN  = 3'd2;

    // Flow control forms.
    localparam logic [2:0] FLOW_IMM_LEN = 3'd5;
    localparam logic [2:0] FLOW_REG_LEN = 3'd1;

    // Anything else is taken one byte at a time.
    localparam logic [2:0] UNKNOWN_LEN = 3'd1;

endpackage

// ==== logic/length_decoder.sv ====
`timescale 1ns/1ps

module length_decoder import fe_types_pkg::*, isa_pkg::*; #(
    parameter int IDB_LEN = 64
) (
    input  byte_t [MAX_INST_BYTES-1:0] head_bytes,
    input  logic [$clog2(IDB_LEN):0]   fill_count,
    input  addr_t                      decode_addr,
    input  logic                       full,
    output iq_entry_t                  entry,
    output logic                       push,
    output ilen_t                      pop_len
);

    localparam int FC_W = $clog2(IDB_LEN) + 1;

    unit_e unit;
    logic  imm;
    logic  gio;
    ilen_t len;

    // Everything the length depends on sits in byte 0.
    assign unit = unit_e'(head_bytes[0][2:0]);
    assign imm  = head_bytes[0][IMM_BIT];
    assign gio  = head_bytes[0][GIO_BIT];

    always_comb begin
        case (unit)
            UNIT_ALU: begin
                len = imm ? ALU_IMM_LEN : ALU_REG_LEN;
            end
            UNIT_MEM: begin
                // Register form is short, else GIO or load/store.
                if (imm) begin
                    len = MEM_REG_LEN;
                end else begin
                    len = gio ? MEM_GIO_LEN : MEM_LDST_LEN;
                end
            end
            UNIT_FLOW: begin
                len = imm ? FLOW_IMM_LEN : FLOW_REG_LEN;
            end
            // Unknown code, step over a single byte.
            default: begin
                len = UNKNOWN_LEN;
            end
        endcase
    end

    // Wait for the whole instruction and a free queue slot.
    assign push    = (fill_count >= FC_W'(len)) && !full;
    assign pop_len = push ? len : '0;

    // Bytes past the instruction length are zeroed.
    always_comb begin
        entry.bits = '0;
        for (int i = 0; i < MAX_INST_BYTES; i++) begin
            if (i < int'(len)) begin
                entry.bits[8*i +: 8] = head_bytes[i];
            end
        end
        entry.addr = decode_addr;
        entry.len  = len;
    end

endmodule

// ==== logic/pc_tracker.sv ====
`timescale 1ns/1ps

module pc_tracker import fe_types_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  jmp,
    input  addr_t pc,
    input  ilen_t pop_len,
    input  logic  req_taken,
    output addr_t decode_addr,
    output addr_t fetch_addr
);

    addr_t next_line;

    // Start of the line after the one just requested.
    assign next_line = (fetch_addr & ~addr_t'(LINE_BYTES - 1)) + addr_t'(LINE_BYTES);

    // Decode address follows the bytes popped from the buffer head.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decode_addr <= '0;
        end else if (jmp) begin
            decode_addr <= pc;
        end else begin
            decode_addr <= decode_addr + addr_t'(pop_len);
        end
    end

    // Fetch address moves one line per accepted request.
    // After a jump it may sit inside a line until the first request goes out.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_addr <= '0;
        end else if (jmp) begin
            fetch_addr <= pc;
        end else if (req_taken) begin
            fetch_addr <= next_line;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module front_end_tb -f flist.f
output="$(./obj_dir/Vfront_end_tb)" || true
echo "$output"
if grep -qx "Everything OK" <<< "$output"; then
    exit 0
fi
exit 1
